// ==== hw/rx_cfg.svh ====
`ifndef RX_CFG_SVH
`define RX_CFG_SVH

// received signal strength in half dB steps
`define RX_RSSI_W 11

// host register bus
`define RX_ADDR_W 8
`define RX_DATA_W 32

// register map
`define RX_REG_THRES 8'd0
// bit 0 is the receive enable
`define RX_REG_CTRL 8'd1

// power threshold after reset
`define RX_THRES_RESET 11'd100

// crc register left by a frame whose fcs is intact
`define RX_FCS_RESIDUE 32'hC704_DD7B

// eight states of four bits each
`define RX_HIST_W 32

`endif

// ==== hw/rx_pkg.sv ====
`include "rx_cfg.svh"

package rx_pkg;

    //////////////////////////////////////////////////
    // controller states
    //////////////////////////////////////////////////

    // the low nibble of each code goes into the state history
    typedef enum logic [4:0] {
        WAIT_POWER    = 5'd0,
        WAIT_PREAMBLE = 5'd1,
        DECODE_SIGNAL = 5'd2,
        CHECK_SIGNAL  = 5'd3,
        SIGNAL_ERROR  = 5'd4,
        DECODE_DATA   = 5'd5,
        DECODE_DONE   = 5'd6
    } rx_state_e;

    // reported with the header pulse and the fcs pulse
    typedef enum logic [4:0] {
        OK               = 5'd0,
        PARITY_FAIL      = 5'd1,
        WRONG_RSVD       = 5'd2,
        WRONG_TAIL       = 5'd3,
        UNSUPPORTED_RATE = 5'd4,
        WRONG_FCS        = 5'd5
    } rx_status_e;

    //////////////////////////////////////////////////
    // packed words
    //////////////////////////////////////////////////

    // legacy SIGNAL field, rate in the lsbs
    typedef struct packed {
        logic [5:0]  tail;
        logic        parity;
        logic [11:0] length;
        logic        reserved;
        logic [3:0]  rate;
    } legacy_sig_t;

    // register block to controller
    typedef struct packed {
        logic [`RX_RSSI_W-1:0] power_thres;
        logic                  rx_enable;
    } rx_config_t;

    // reported with a good header
    typedef struct packed {
        logic [11:0] length;
        logic [3:0]  rate;
    } pkt_info_t;

endpackage

// ==== hw/rx_config_regs.sv ====
`timescale 1ns/1ns
`include "rx_cfg.svh"

module rx_config_regs (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  set_stb_i,
    input  logic [`RX_ADDR_W-1:0] set_addr_i,
    input  logic [`RX_DATA_W-1:0] set_data_i,
    output rx_pkg::rx_config_t    cfg_o
);
    import rx_pkg::*;

    rx_config_t cfg_q;
    logic       wr_thres;
    logic       wr_ctrl;

    // address decode
    assign wr_thres = set_stb_i && (set_addr_i == `RX_REG_THRES);
    assign wr_ctrl  = set_stb_i && (set_addr_i == `RX_REG_CTRL);

    // other addresses fall through untouched
    always_ff @(posedge clock) begin
        if (reset) begin
            cfg_q.power_thres <= `RX_THRES_RESET;
            cfg_q.rx_enable   <= 1'b1;
        end else begin
            if (wr_thres) begin
                cfg_q.power_thres <= set_data_i[`RX_RSSI_W-1:0];
            end
            if (wr_ctrl) begin
                cfg_q.rx_enable <= set_data_i[0];
            end
        end
    end

    assign cfg_o = cfg_q;

endmodule

// ==== hw/fcs_crc32.sv ====
`timescale 1ns/1ns

module fcs_crc32 (
    input  logic        clock,
    input  logic        reset,
    input  logic        restart_i,
    input  logic        byte_en_i,
    input  logic [7:0]  byte_i,
    output logic [31:0] crc_o
);

    localparam logic [31:0] crc_poly = 32'h04C1_1DB7;

    logic [7:0]  byte_rev;
    logic [31:0] crc_q;
    logic [31:0] crc_next;

    // bit 0 is first on air, so it goes to the msb
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            byte_rev[i] = byte_i[7 - i];
        end
    end

    // eight serial lfsr steps per byte, msb first
    always_comb begin
        crc_next = crc_q;
        for (int i = 7; i >= 0; i--) begin
            if (crc_next[31] ^ byte_rev[i]) begin
                crc_next = {crc_next[30:0], 1'b0} ^ crc_poly;
            end else begin
                crc_next = {crc_next[30:0], 1'b0};
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            crc_q <= '0;
        end else if (restart_i) begin
            crc_q <= '0;
        end else if (byte_en_i) begin
            crc_q <= crc_next;
        end
    end

    assign crc_o = crc_q;

endmodule

// ==== hw/rx_ctrl.sv ====
`timescale 1ns/1ns
`include "rx_cfg.svh"

module rx_ctrl (
    input  logic                  clock,
    input  logic                  reset,
    input  rx_pkg::rx_config_t    cfg_i,
    input  logic [`RX_RSSI_W-1:0] rssi_i,
    input  logic                  preamble_i,
    input  logic [7:0]            byte_i,
    input  logic                  byte_strobe_i,
    input  logic [31:0]           crc_i,
    output logic                  crc_restart_o,
    output logic                  crc_byte_en_o,
    output logic [7:0]            byte_o,
    output logic                  byte_strobe_o,
    output rx_pkg::pkt_info_t     pkt_info_o,
    output logic                  header_valid_o,
    output logic                  header_valid_strobe_o,
    output logic                  pkt_begin_o,
    output logic                  fcs_strobe_o,
    output logic                  fcs_ok_o,
    output rx_pkg::rx_status_e    status_o,
    output logic                  demod_ongoing_o,
    output logic [`RX_HIST_W-1:0] state_history_o
);
    import rx_pkg::*;

    rx_state_e   state_q;
    rx_state_e   state_d;
    legacy_sig_t sig_q;
    rx_status_e  sig_status;
    logic [1:0]  sig_cnt_q;
    logic [11:0] data_cnt_q;
    logic        power_trig;
    logic        sig_shift;
    logic        sig_err;
    logic        len_done;
    logic        data_byte;
    logic        crc_good;

    //////////////////////////////////////////////////
    // decode helpers
    //////////////////////////////////////////////////

    // receive enable low keeps the trigger off
    assign power_trig = cfg_i.rx_enable && (rssi_i >= cfg_i.power_thres);

    assign sig_shift = (state_q == DECODE_SIGNAL) && byte_strobe_i && (sig_cnt_q != 2'd3);
    assign len_done  = data_cnt_q >= pkt_info_o.length;
    assign data_byte = (state_q == DECODE_DATA) && byte_strobe_i && !len_done;
    assign crc_good  = crc_i == `RX_FCS_RESIDUE;

    // checks in priority order
    always_comb begin
        if (^sig_q[17:0]) begin
            sig_status = PARITY_FAIL;
        end else if (sig_q.reserved) begin
            sig_status = WRONG_RSVD;
        end else if (|sig_q.tail) begin
            sig_status = WRONG_TAIL;
        end else if (!sig_q.rate[3]) begin
            sig_status = UNSUPPORTED_RATE;
        end else begin
            sig_status = OK;
        end
    end

    assign sig_err = sig_status != OK;

    // data bytes pass straight through
    assign byte_o        = byte_i;
    assign byte_strobe_o = data_byte;
    assign crc_byte_en_o = data_byte;
    // crc cleared while the header is judged
    assign crc_restart_o = state_q == CHECK_SIGNAL;

    //////////////////////////////////////////////////
    // state machine
    //////////////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            WAIT_POWER: begin
                if (power_trig) begin
                    state_d = WAIT_PREAMBLE;
                end
            end
            WAIT_PREAMBLE: begin
                // a preamble pulse wins over a power drop
                if (preamble_i) begin
                    state_d = DECODE_SIGNAL;
                end else if (!power_trig) begin
                    state_d = WAIT_POWER;
                end
            end
            DECODE_SIGNAL: begin
                if (sig_cnt_q == 2'd3) begin
                    state_d = CHECK_SIGNAL;
                end
            end
            CHECK_SIGNAL: begin
                state_d = sig_err ? SIGNAL_ERROR : DECODE_DATA;
            end
            DECODE_DATA: begin
                if (len_done) begin
                    state_d = DECODE_DONE;
                end
            end
            default: begin
                state_d = WAIT_POWER;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state_q         <= WAIT_POWER;
            state_history_o <= '0;
        end else begin
            state_q <= state_d;
            if (state_d != state_q) begin
                state_history_o <= {state_history_o[`RX_HIST_W-5:0], state_d[3:0]};
            end
        end
    end

    // byte counters
    always_ff @(posedge clock) begin
        if (reset) begin
            sig_cnt_q  <= '0;
            data_cnt_q <= '0;
        end else begin
            if (state_q == WAIT_PREAMBLE) begin
                sig_cnt_q <= '0;
            end else if (sig_shift) begin
                sig_cnt_q <= sig_cnt_q + 2'd1;
            end
            if (state_q == CHECK_SIGNAL) begin
                data_cnt_q <= '0;
            end else if (data_byte) begin
                data_cnt_q <= data_cnt_q + 12'd1;
            end
        end
    end

    // SIGNAL word fills from the top, first byte ends in the lsbs
    always_ff @(posedge clock) begin
        if (sig_shift) begin
            sig_q <= legacy_sig_t'({byte_i, sig_q[23:8]});
        end
        if (state_q == CHECK_SIGNAL) begin
            pkt_info_o.rate   <= sig_q.rate;
            pkt_info_o.length <= sig_q.length;
        end
    end

    //////////////////////////////////////////////////
    // pulses and status
    //////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            header_valid_strobe_o <= 1'b0;
            header_valid_o        <= 1'b0;
            pkt_begin_o           <= 1'b0;
            fcs_strobe_o          <= 1'b0;
            fcs_ok_o              <= 1'b0;
            status_o              <= OK;
            demod_ongoing_o       <= 1'b0;
        end else begin
            header_valid_strobe_o <= 1'b0;
            header_valid_o        <= 1'b0;
            pkt_begin_o           <= 1'b0;
            fcs_strobe_o          <= 1'b0;
            fcs_ok_o              <= 1'b0;
            case (state_q)
                WAIT_PREAMBLE: begin
                    if (preamble_i) begin
                        demod_ongoing_o <= 1'b1;
                    end
                end
                CHECK_SIGNAL: begin
                    header_valid_strobe_o <= 1'b1;
                    header_valid_o        <= !sig_err;
                    pkt_begin_o           <= !sig_err;
                    status_o              <= sig_status;
                    if (sig_err) begin
                        demod_ongoing_o <= 1'b0;
                    end
                end
                DECODE_DATA: begin
                    // crc already holds the last byte here
                    if (len_done) begin
                        fcs_strobe_o    <= 1'b1;
                        fcs_ok_o        <= crc_good;
                        status_o        <= crc_good ? OK : WRONG_FCS;
                        demod_ongoing_o <= 1'b0;
                    end
                end
                default: begin
                end
            endcase
        end
    end

endmodule

// ==== hw/rx_top.sv ====
`timescale 1ns/1ns
`include "rx_cfg.svh"

module rx_top (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  set_stb_i,
    input  logic [`RX_ADDR_W-1:0] set_addr_i,
    input  logic [`RX_DATA_W-1:0] set_data_i,
    input  logic [`RX_RSSI_W-1:0] rssi_i,
    input  logic                  preamble_i,
    input  logic [7:0]            byte_i,
    input  logic                  byte_strobe_i,
    output logic [7:0]            byte_o,
    output logic                  byte_strobe_o,
    output rx_pkg::pkt_info_t     pkt_info_o,
    output logic                  header_valid_o,
    output logic                  header_valid_strobe_o,
    output logic                  pkt_begin_o,
    output logic                  fcs_strobe_o,
    output logic                  fcs_ok_o,
    output rx_pkg::rx_status_e    status_o,
    output logic                  demod_ongoing_o,
    output logic [`RX_HIST_W-1:0] state_history_o
);
    import rx_pkg::*;

    rx_config_t  cfg;
    logic        crc_restart;
    logic        crc_byte_en;
    logic [31:0] crc;

    rx_config_regs rx_config_regs_i (
        .clock      (clock),
        .reset      (reset),
        .set_stb_i  (set_stb_i),
        .set_addr_i (set_addr_i),
        .set_data_i (set_data_i),
        .cfg_o      (cfg)
    );

    rx_ctrl rx_ctrl_i (
        .clock                 (clock),
        .reset                 (reset),
        .cfg_i                 (cfg),
        .rssi_i                (rssi_i),
        .preamble_i            (preamble_i),
        .byte_i                (byte_i),
        .byte_strobe_i         (byte_strobe_i),
        .crc_i                 (crc),
        .crc_restart_o         (crc_restart),
        .crc_byte_en_o         (crc_byte_en),
        .byte_o                (byte_o),
        .byte_strobe_o         (byte_strobe_o),
        .pkt_info_o            (pkt_info_o),
        .header_valid_o        (header_valid_o),
        .header_valid_strobe_o (header_valid_strobe_o),
        .pkt_begin_o           (pkt_begin_o),
        .fcs_strobe_o          (fcs_strobe_o),
        .fcs_ok_o              (fcs_ok_o),
        .status_o              (status_o),
        .demod_ongoing_o       (demod_ongoing_o),
        .state_history_o       (state_history_o)
    );

    // fed from the forwarded data bytes only
    fcs_crc32 fcs_crc32_i (
        .clock     (clock),
        .reset     (reset),
        .restart_i (crc_restart),
        .byte_en_i (crc_byte_en),
        .byte_i    (byte_o),
        .crc_o     (crc)
    );

endmodule

// ==== testbench/rx_checker.sv ====
`timescale 1ns/1ns
`include "rx_cfg.svh"

module rx_checker (
    input  logic                  clock,
    input  logic                  reset,
    input  logic [7:0]            byte_i,
    input  logic                  byte_strobe_i,
    input  rx_pkg::pkt_info_t     pkt_info_i,
    input  logic                  header_valid_i,
    input  logic                  header_strobe_i,
    input  logic                  pkt_begin_i,
    input  logic                  fcs_strobe_i,
    input  logic                  fcs_ok_i,
    input  rx_pkg::rx_status_e    status_i,
    input  logic                  demod_ongoing_i,
    input  logic [`RX_HIST_W-1:0] history_i
);
    import rx_pkg::*;

    typedef struct packed {
        logic        valid;
        logic [4:0]  status;
        logic [3:0]  rate;
        logic [11:0] length;
    } hdr_exp_t;

    typedef struct packed {
        logic       ok;
        logic [4:0] status;
    } fcs_exp_t;

    // state codes of one full frame in order of visit
    localparam logic [19:0] frame_walk = {4'(WAIT_PREAMBLE), 4'(DECODE_SIGNAL),
        4'(CHECK_SIGNAL), 4'(DECODE_DATA), 4'(DECODE_DONE)};

    hdr_exp_t   hdr_q[$];
    fcs_exp_t   fcs_q[$];
    logic [7:0] byte_q[$];
    hdr_exp_t   hdr;
    fcs_exp_t   fcs;
    logic [7:0] exp_byte;
    logic       no_header = 1'b0;
    logic       in_reset = 1'b1;
    int         checks = 0;
    int         errors = 0;

    task automatic expect_header(input hdr_exp_t h);
        hdr_q.push_back(h);
    endtask

    task automatic expect_fcs(input fcs_exp_t f);
        fcs_q.push_back(f);
    endtask

    task automatic expect_byte(input logic [7:0] b);
        byte_q.push_back(b);
    endtask

    task automatic set_no_header(input logic on);
        no_header = on;
    endtask

    function automatic int headers_pending();
        return hdr_q.size();
    endfunction

    function automatic int fcs_pending();
        return fcs_q.size();
    endfunction

    function automatic int bytes_pending();
        return byte_q.size();
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %0t: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic complain(input string msg);
        errors++;
        $display("%s at time %0t", msg, $time);
    endtask

    // give up on pulses that never came
    task automatic drop_missing();
        while (hdr_q.size() != 0) begin
            void'(hdr_q.pop_front());
            complain("an expected header pulse never came");
        end
        while (fcs_q.size() != 0) begin
            void'(fcs_q.pop_front());
            complain("an expected fcs pulse never came");
        end
    endtask

    //////////////////////////////////////////////////
    // compare at each rising edge
    //////////////////////////////////////////////////

    always @(posedge clock) begin
        if (reset) begin
            in_reset = 1'b1;
        end else begin
            // first cycle out of reset
            if (in_reset) begin
                check_value("status_o after reset", 32'(status_i), 32'(OK));
                check_value("state history after reset", 32'(history_i), 32'd0);
                check_value("demod_ongoing_o after reset", 32'(demod_ongoing_i), 32'd0);
                in_reset = 1'b0;
            end
            if (byte_strobe_i) begin
                if (byte_q.size() == 0) begin
                    complain("a byte was forwarded when none was expected");
                end else begin
                    exp_byte = byte_q.pop_front();
                    check_value("byte_o", 32'(byte_i), 32'(exp_byte));
                    check_value("demod_ongoing_o with data", 32'(demod_ongoing_i), 32'd1);
                end
            end
            if (header_strobe_i) begin
                if (no_header || hdr_q.size() == 0) begin
                    complain("a header pulse came when none was expected");
                end else begin
                    hdr = hdr_q.pop_front();
                    check_value("header_valid_o", 32'(header_valid_i), 32'(hdr.valid));
                    check_value("pkt_begin_o", 32'(pkt_begin_i), 32'(hdr.valid));
                    check_value("header status_o", 32'(status_i), 32'(hdr.status));
                    check_value("demod_ongoing_o at header", 32'(demod_ongoing_i),
                                32'(hdr.valid));
                    if (hdr.valid) begin
                        check_value("rate", 32'(pkt_info_i.rate), 32'(hdr.rate));
                        check_value("length", 32'(pkt_info_i.length), 32'(hdr.length));
                    end
                end
            end
            if (fcs_strobe_i) begin
                if (fcs_q.size() == 0) begin
                    complain("an fcs pulse came when none was expected");
                end else begin
                    fcs = fcs_q.pop_front();
                    check_value("fcs_ok_o", 32'(fcs_ok_i), 32'(fcs.ok));
                    check_value("fcs status_o", 32'(status_i), 32'(fcs.status));
                    check_value("demod_ongoing_o at fcs", 32'(demod_ongoing_i), 32'd0);
                    check_value("state history", 32'(history_i[19:0]), 32'(frame_walk));
                end
            end
        end
    end

endmodule

// ==== testbench/rx_top_chk.sv ====
`timescale 1ns/1ns

module rx_top_chk (
    input logic clock,
    input logic reset,
    input logic byte_strobe_i,
    input logic byte_strobe_o,
    input logic header_valid_strobe_o,
    input logic pkt_begin_o,
    input logic fcs_strobe_o,
    input logic fcs_ok_o
);

    // single cycle pulses
    a_hdr_pulse: assert property (@(posedge clock) disable iff (reset)
        header_valid_strobe_o |=> !header_valid_strobe_o)
        else $error("header strobe held longer than one cycle");
    a_begin_pulse: assert property (@(posedge clock) disable iff (reset)
        pkt_begin_o |=> !pkt_begin_o)
        else $error("packet begin held longer than one cycle");
    a_fcs_pulse: assert property (@(posedge clock) disable iff (reset)
        fcs_strobe_o |=> !fcs_strobe_o)
        else $error("fcs strobe held longer than one cycle");

    a_fcs_ok: assert property (@(posedge clock) disable iff (reset)
        fcs_ok_o |-> fcs_strobe_o)
        else $error("fcs_ok high without fcs strobe");
    a_byte_fwd: assert property (@(posedge clock) disable iff (reset)
        byte_strobe_o |-> byte_strobe_i)
        else $error("byte strobe out without byte strobe in");

    // quiet outputs right after reset
    a_reset_quiet: assert property (@(posedge clock)
        $fell(reset) |-> !(header_valid_strobe_o || pkt_begin_o || fcs_strobe_o
                           || byte_strobe_o))
        else $error("strobe high in first cycle after reset");

endmodule

bind rx_top rx_top_chk rx_top_chk_i (
    .clock                 (clock),
    .reset                 (reset),
    .byte_strobe_i         (byte_strobe_i),
    .byte_strobe_o         (byte_strobe_o),
    .header_valid_strobe_o (header_valid_strobe_o),
    .pkt_begin_o           (pkt_begin_o),
    .fcs_strobe_o          (fcs_strobe_o),
    .fcs_ok_o              (fcs_ok_o)
);

// ==== testbench/tb_rx_top.sv ====
`timescale 1ns/1ns
`include "rx_cfg.svh"

module tb_rx_top;
    import rx_pkg::*;

    logic                  clock = 1'b0;
    logic                  reset;
    logic                  set_stb_i;
    logic [`RX_ADDR_W-1:0] set_addr_i;
    logic [`RX_DATA_W-1:0] set_data_i;
    logic [`RX_RSSI_W-1:0] rssi_i;
    logic                  preamble_i;
    logic [7:0]            byte_i;
    logic                  byte_strobe_i;
    logic [7:0]            byte_o;
    logic                  byte_strobe_o;
    pkt_info_t             pkt_info_o;
    logic                  header_valid_o;
    logic                  header_valid_strobe_o;
    logic                  pkt_begin_o;
    logic                  fcs_strobe_o;
    logic                  fcs_ok_o;
    rx_status_e            status_o;
    logic                  demod_ongoing_o;
    logic [`RX_HIST_W-1:0] state_history_o;

    int   cycles = 0;
    int   cycle_limit = 100000;
    int   tb_errors = 0;
    logic in_data = 1'b0;

    always #2 clock = ~clock;

    rx_top rx_top_i (.*);

    rx_checker rx_checker_i (
        .clock           (clock),
        .reset           (reset),
        .byte_i          (byte_o),
        .byte_strobe_i   (byte_strobe_o),
        .pkt_info_i      (pkt_info_o),
        .header_valid_i  (header_valid_o),
        .header_strobe_i (header_valid_strobe_o),
        .pkt_begin_i     (pkt_begin_o),
        .fcs_strobe_i    (fcs_strobe_o),
        .fcs_ok_i        (fcs_ok_o),
        .status_i        (status_o),
        .demod_ongoing_i (demod_ongoing_o),
        .history_i       (state_history_o)
    );

    //////////////////////////////////////////////////
    // stimulus helpers on the falling edge
    //////////////////////////////////////////////////

    // wait for the checker to take the pulse, then give up
    task automatic wait_for_pulses();
        int n;
        n = 0;
        while ((rx_checker_i.headers_pending() != 0 || rx_checker_i.fcs_pending() != 0)
               && n < 40) begin
            @(negedge clock);
            n++;
        end
        rx_checker_i.drop_missing();
    endtask

    // one strobed byte with no idle cycles before it
    task automatic strobe_byte(input logic [7:0] value);
        byte_i        = value;
        byte_strobe_i = 1'b1;
        @(negedge clock);
        byte_strobe_i = 1'b0;
    endtask

    // bytes that must be dropped outside the data phase
    task automatic send_idle_bytes(input int count);
        for (int k = 0; k < count; k++) begin
            strobe_byte(8'(8'hC0 + k));
        end
    endtask

    task automatic run_record(input string rec);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] d;
        int          gap;
        a = '0;
        b = '0;
        c = '0;
        d = '0;
        void'($sscanf(rec.substr(1, rec.len() - 1), "%h %h %h %h", a, b, c, d));
        case (rec[0])
            "W": begin
                set_stb_i  = 1'b1;
                set_addr_i = a[`RX_ADDR_W-1:0];
                set_data_i = b;
                @(negedge clock);
                set_stb_i = 1'b0;
            end
            "R": begin
                rssi_i = a[`RX_RSSI_W-1:0];
                rx_checker_i.set_no_header(1'b0);
                repeat (3) @(negedge clock);
            end
            "P": begin
                // room for the controller to reach WAIT_PREAMBLE
                repeat (2) @(negedge clock);
                preamble_i = 1'b1;
                @(negedge clock);
                preamble_i = 1'b0;
            end
            "B": begin
                gap = int'($urandom % 4);
                repeat (gap) @(negedge clock);
                if (in_data) begin
                    rx_checker_i.expect_byte(a[7:0]);
                end
                strobe_byte(a[7:0]);
            end
            "H": begin
                rx_checker_i.expect_header({a[0], b[4:0], c[3:0], d[11:0]});
                in_data = a[0];
                wait_for_pulses();
                // a rejected SIGNAL word opens no data phase
                if (!a[0]) begin
                    send_idle_bytes(16);
                end
            end
            "F": begin
                rx_checker_i.expect_fcs({a[0], b[4:0]});
                wait_for_pulses();
                in_data = 1'b0;
            end
            "N": begin
                rx_checker_i.set_no_header(1'b1);
                // enough for a SIGNAL field if the preamble had been taken
                send_idle_bytes(3);
                repeat (20) @(negedge clock);
            end
            default: begin
                tb_errors++;
                $display("unknown record in case file: %s", rec);
            end
        endcase
    endtask

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////

    initial begin
        int    fd;
        string line;
        string recs[$];
        int    total;
        void'($urandom(85));
        reset         = 1'b1;
        set_stb_i     = 1'b0;
        set_addr_i    = '0;
        set_data_i    = '0;
        rssi_i        = '0;
        preamble_i    = 1'b0;
        byte_i        = '0;
        byte_strobe_i = 1'b0;
        repeat (4) @(negedge clock);
        reset = 1'b0;

        fd = $fopen("testbench/rx_cases.txt", "r");
        if (fd == 0) begin
            tb_errors++;
            $display("the case file could not be opened");
        end else begin
            while ($fgets(line, fd)) begin
                if (line.len() > 1 && line[0] != "#") begin
                    recs.push_back(line);
                end
            end
            $fclose(fd);
        end
        cycle_limit = recs.size() * 5 + 200;

        foreach (recs[i]) begin
            run_record(recs[i]);
        end
        repeat (10) @(negedge clock);
        if (rx_checker_i.bytes_pending() != 0) begin
            tb_errors++;
            $display("some expected data bytes were never forwarded");
        end

        total = rx_checker_i.errors + tb_errors;
        $display("checks %0d, errors %0d", rx_checker_i.checks, total);
        if (total == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // run length guard
    always @(posedge clock) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout, run stopped after %0d cycles", cycles);
            $display(">>> FAIL");
            $finish;
        end
    end

endmodule

// ==== testbench/rx_cases.txt ====
# kind then hex fields: W addr data, R rssi, P preamble, B byte
# H valid status rate length, F fcs_ok status, N no header before next R
R 078
P
B AD
B 01
B 00
H 1 00 D 00D
B CE
B CD
B CC
B CB
B 35
B 36
B 37
B 38
B 39
B 26
B 39
B F4
B CB
F 1 00
R 078
P
B 8D
B 00
B 00
H 1 00 D 004
B FF
B FF
B FE
B FF
F 0 05
R 078
P
B AD
B 01
B 02
H 0 01 0 000
P
B BD
B 01
B 02
H 0 02 0 000
P
B AD
B 01
B 04
H 0 03 0 000
P
B A5
B 01
B 02
H 0 04 0 000
R 050
P
B AD
N
R 078
R 030
P
N
W 0 0C8
R 096
P
B AD
N
W 0 064
W 1 0
R 078
P
B AD
B 01
B 00
N
W 1 1
R 078
P
B 8D
B 00
B 00
H 1 00 D 004
B FF
B FF
B FF
B FF
F 1 00

// ==== sim.f ====
+incdir+hw
hw/rx_pkg.sv
hw/rx_config_regs.sv
hw/fcs_crc32.sv
hw/rx_ctrl.sv
hw/rx_top.sv
testbench/rx_checker.sv
testbench/rx_top_chk.sv
testbench/tb_rx_top.sv

// ==== run_sim.sh ====
#!/bin/bash
# build and run with Verilator from the project root
verilator --binary --timing --assert -f sim.f --top-module tb_rx_top -o sim_rx \
    && ./obj_dir/sim_rx > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }
cat sim.log
grep -q ">>> FAIL" sim.log && exit 1 || grep -q ">>> PASS" sim.log
